// File: verilog/fram_cfg_pkg.sv
`default_nettype none

package fram_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [7:0]  fram_byte_t;
	typedef logic [15:0] fram_addr_t;
	typedef logic [10:0] fram_len_t;
	typedef logic [31:0] crc_t;

	// SPI FRAM read opcode
	localparam fram_byte_t FRAM_CMD_READ = 8'h03;

	// Image is payload followed by its CRC, LSB first
	localparam fram_len_t  CFG_LOAD_LEN  = 11'd900;
	localparam fram_addr_t CFG_BASE_ADDR = 16'h0400;
	localparam int         CFG_RAM_AW    = 10;

	// Reflected CRC-32, residue taken over data plus stored CRC
	localparam crc_t CRC_POLY_REFL = 32'hEDB88320;
	localparam crc_t CRC_INIT      = 32'hFFFFFFFF;
	localparam crc_t CRC_RESIDUE   = 32'hDEBB20E3;

	// sys_clk cycles per SCLK bit, split evenly high and low
	localparam int SCLK_DIV = 2;

	////////////////////////////////////////////////////////////////////////////
	// State machines
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic {idle, wr_co} load_state_t;
	typedef enum logic [1:0] {spi_idle, spi_cmd, spi_data, spi_finish} spi_state_t;

endpackage

`default_nettype wire

// File: verilog/crc32_byte_check.sv
`default_nettype none

module crc32_byte_check
	import fram_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       glbl_rst_n,
	input  logic       crc_init,
	input  logic       crc_en,
	input  fram_byte_t crc_data,
	input  logic       crc_end,
	output logic       crc_ok
);

	crc_t crc_q;
	crc_t crc_next;

	// One byte through the reflected LFSR, bit 0 first
	function automatic crc_t crc_byte(input crc_t crc_in, input fram_byte_t data);
		crc_t c;
		c = crc_in;
		for (int i = 0; i < 8; i++)
		begin
			c = (c >> 1) ^ (CRC_POLY_REFL & {32{c[0] ^ data[i]}});
		end
		return c;
	endfunction

	assign crc_next = crc_byte(crc_q, crc_data);

	////////////////////////////////////////////////////////////////////////////
	// Running CRC
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			crc_q <= CRC_INIT;
		else if (crc_init)
			crc_q <= CRC_INIT;
		else if (crc_en)
			crc_q <= crc_next;
	end

	////////////////////////////////////////////////////////////////////////////
	// Residue compare
	////////////////////////////////////////////////////////////////////////////

	// Stored CRC is part of the stream, so a clean image leaves the residue
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			crc_ok <= 1'b0;
		end
		else
		begin
			if (crc_init)
			begin
				crc_ok <= 1'b0;
			end
			else if (crc_end)
			begin
				crc_ok <= (crc_q == CRC_RESIDUE);
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fram_spi_reader.sv
`default_nettype none

module fram_spi_reader
	import fram_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       glbl_rst_n,
	input  logic       rd_req,
	input  fram_addr_t rd_addr,
	input  fram_len_t  rd_len,
	output logic       byte_valid,
	output logic       byte_last,
	output fram_byte_t byte_data,
	output logic       fram_cs_n,
	output logic       fram_sclk,
	output logic       fram_mosi,
	input  logic       fram_miso
);

	spi_state_t  state;
	logic [3:0]  div_cnt;
	logic        half_tick;
	logic        sclk_rise;
	logic        sclk_fall;
	logic [23:0] tx_shift;
	logic [4:0]  bit_cnt;
	logic [6:0]  rx_shift;
	fram_len_t   len_cnt;

	////////////////////////////////////////////////////////////////////////////
	// SCLK generation, mode 0
	////////////////////////////////////////////////////////////////////////////

	assign half_tick = (div_cnt == 4'(SCLK_DIV / 2 - 1));
	assign sclk_rise = half_tick & ~fram_sclk;
	assign sclk_fall = half_tick & fram_sclk;

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			div_cnt <= '0;
		else if (state == spi_idle || half_tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 4'd1;
	end

	// Idles low between transfers
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			fram_sclk <= 1'b0;
		else if (state == spi_idle)
			fram_sclk <= 1'b0;
		else if (half_tick)
			fram_sclk <= ~fram_sclk;
	end

	// Command and address go out MSB first
	assign fram_mosi = (state == spi_cmd) ? tx_shift[23] : 1'b0;

	////////////////////////////////////////////////////////////////////////////
	// Transfer FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state      <= spi_idle;
			fram_cs_n  <= 1'b1;
			byte_valid <= 1'b0;
			byte_last  <= 1'b0;
		end
		else
		begin
			byte_valid <= 1'b0;
			byte_last  <= 1'b0;
			case (state)
				spi_idle:
				begin
					if (rd_req)
					begin
						state     <= spi_cmd;
						fram_cs_n <= 1'b0;
					end
				end
				spi_cmd:
				begin
					// Leave after the 24th bit has been clocked out
					if (sclk_fall && bit_cnt == 5'd0)
						state <= spi_data;
				end
				spi_data:
				begin
					if (sclk_rise && bit_cnt == 5'd0)
					begin
						byte_valid <= 1'b1;
						byte_last  <= (len_cnt == 11'd1);
						if (len_cnt == 11'd1)
							state <= spi_finish;
					end
				end
				spi_finish:
				begin
					// Return SCLK low before deselecting the part
					if (sclk_fall)
					begin
						state     <= spi_idle;
						fram_cs_n <= 1'b1;
					end
				end
				default:
				begin
					state     <= spi_idle;
					fram_cs_n <= 1'b1;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift registers and counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (state == spi_idle && rd_req)
		begin
			tx_shift <= {FRAM_CMD_READ, rd_addr};
			bit_cnt  <= 5'd23;
			len_cnt  <= rd_len;
		end
		else if (state == spi_cmd && sclk_fall)
		begin
			tx_shift <= {tx_shift[22:0], 1'b0};
			bit_cnt  <= (bit_cnt == 5'd0) ? 5'd7 : bit_cnt - 5'd1;
		end
		else if (state == spi_data && sclk_rise)
		begin
			rx_shift <= {rx_shift[5:0], fram_miso};
			if (bit_cnt == 5'd0)
			begin
				byte_data <= {rx_shift, fram_miso};
				len_cnt   <= len_cnt - 11'd1;
				bit_cnt   <= 5'd7;
			end
			else
			begin
				bit_cnt <= bit_cnt - 5'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fram_load_cons.sv
`default_nettype none

module fram_load_cons
	import fram_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       glbl_rst_n,
	input  logic       fram_cons_en,
	output logic       fram_cons_done,
	output logic       fram_cons_error,
	output logic       cons_fram_rden,
	output fram_len_t  cons_fram_length,
	output fram_addr_t cons_fram_addr,
	input  logic       init_fram_valid,
	input  logic       init_fram_last,
	input  fram_byte_t init_fram_data,
	output logic       fram_cons_wren,
	output fram_addr_t fram_cons_addr,
	output fram_byte_t fram_cons_data,
	output crc_t       fram_cons_crc,
	output logic       crc_end,
	input  logic       crc_ok
);

	load_state_t state;
	logic        start_ok;
	logic        last_d1;
	logic        last_d2;

	// Starts are only taken from idle
	assign start_ok = fram_cons_en & (state == idle);

	////////////////////////////////////////////////////////////////////////////
	// Read request towards the SPI reader
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			cons_fram_rden   <= 1'b0;
			cons_fram_length <= '0;
			cons_fram_addr   <= '0;
		end
		else
		begin
			cons_fram_rden <= start_ok;
			if (start_ok)
			begin
				cons_fram_length <= CFG_LOAD_LEN;
				cons_fram_addr   <= '0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Config write and stored CRC capture
	////////////////////////////////////////////////////////////////////////////

	assign fram_cons_wren = init_fram_valid & (state == wr_co);
	assign fram_cons_data = init_fram_data;

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			state          <= idle;
			fram_cons_addr <= CFG_BASE_ADDR;
		end
		else
		begin
			case (state)
				idle:
				begin
					if (fram_cons_en)
					begin
						state          <= wr_co;
						fram_cons_addr <= CFG_BASE_ADDR;
					end
				end
				wr_co:
				begin
					if (init_fram_valid)
						fram_cons_addr <= fram_cons_addr + 16'd1;
					if (last_d2)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Last four bytes end up as a little endian word
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
			fram_cons_crc <= '0;
		else if (fram_cons_wren)
			fram_cons_crc <= {init_fram_data, fram_cons_crc[31:8]};
	end

	////////////////////////////////////////////////////////////////////////////
	// End of image
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			last_d1 <= 1'b0;
			last_d2 <= 1'b0;
		end
		else
		begin
			last_d1 <= init_fram_valid & init_fram_last & (state == wr_co);
			last_d2 <= last_d1;
		end
	end

	assign crc_end = last_d1;

	// crc_ok settles one cycle after crc_end
	assign fram_cons_done  = last_d2 & crc_ok;
	assign fram_cons_error = last_d2 & ~crc_ok;

endmodule

`default_nettype wire

// File: verilog/cons_ram.sv
`default_nettype none

module cons_ram
	import fram_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       wr_en,
	input  fram_addr_t wr_addr,
	input  fram_byte_t wr_data,
	input  fram_addr_t cfg_rd_addr,
	output fram_byte_t cfg_rd_data
);

	// Indexed by the low address bits only
	fram_byte_t mem [0:(1 << CFG_RAM_AW) - 1];

	logic [CFG_RAM_AW-1:0] wr_idx;
	logic [CFG_RAM_AW-1:0] rd_idx;

	assign wr_idx = wr_addr[CFG_RAM_AW-1:0];
	assign rd_idx = cfg_rd_addr[CFG_RAM_AW-1:0];

	// Loader side
	always_ff @(posedge sys_clk)
	begin
		if (wr_en)
			mem[wr_idx] <= wr_data;
	end

	// Consumer side, one cycle latency
	always_ff @(posedge sys_clk)
	begin
		cfg_rd_data <= mem[rd_idx];
	end

endmodule

`default_nettype wire

// File: verilog/fram_cfg_top.sv
`default_nettype none

module fram_cfg_top
	import fram_cfg_pkg::*;
(
	input  logic       sys_clk,
	input  logic       glbl_rst_n,
	input  logic       load_start,
	output logic       load_done,
	output logic       load_error,
	output crc_t       load_crc,
	input  fram_addr_t cfg_rd_addr,
	output fram_byte_t cfg_rd_data,
	output logic       fram_cs_n,
	output logic       fram_sclk,
	output logic       fram_mosi,
	input  logic       fram_miso
);

	logic       rd_req;
	fram_len_t  rd_len;
	fram_addr_t rd_addr;
	logic       byte_valid;
	logic       byte_last;
	fram_byte_t byte_data;
	logic       wr_en;
	fram_addr_t wr_addr;
	fram_byte_t wr_data;
	logic       crc_end;
	logic       crc_ok;

	////////////////////////////////////////////////////////////////////////////
	// SPI reader
	////////////////////////////////////////////////////////////////////////////

	fram_spi_reader i_reader (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.rd_req     (rd_req),
		.rd_addr    (rd_addr),
		.rd_len     (rd_len),
		.byte_valid (byte_valid),
		.byte_last  (byte_last),
		.byte_data  (byte_data),
		.fram_cs_n  (fram_cs_n),
		.fram_sclk  (fram_sclk),
		.fram_mosi  (fram_mosi),
		.fram_miso  (fram_miso)
	);

	////////////////////////////////////////////////////////////////////////////
	// Loader, CRC check and config RAM
	////////////////////////////////////////////////////////////////////////////

	fram_load_cons i_loader (
		.sys_clk          (sys_clk),
		.glbl_rst_n       (glbl_rst_n),
		.fram_cons_en     (load_start),
		.fram_cons_done   (load_done),
		.fram_cons_error  (load_error),
		.cons_fram_rden   (rd_req),
		.cons_fram_length (rd_len),
		.cons_fram_addr   (rd_addr),
		.init_fram_valid  (byte_valid),
		.init_fram_last   (byte_last),
		.init_fram_data   (byte_data),
		.fram_cons_wren   (wr_en),
		.fram_cons_addr   (wr_addr),
		.fram_cons_data   (wr_data),
		.fram_cons_crc    (load_crc),
		.crc_end          (crc_end),
		.crc_ok           (crc_ok)
	);

	// Seeded by the accepted start, so a start during a load leaves the CRC alone
	crc32_byte_check i_crc (
		.sys_clk    (sys_clk),
		.glbl_rst_n (glbl_rst_n),
		.crc_init   (rd_req),
		.crc_en     (byte_valid),
		.crc_data   (byte_data),
		.crc_end    (crc_end),
		.crc_ok     (crc_ok)
	);

	cons_ram i_ram (
		.sys_clk     (sys_clk),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.cfg_rd_addr (cfg_rd_addr),
		.cfg_rd_data (cfg_rd_data)
	);

endmodule

`default_nettype wire

// File: verification/spi_fram_model.sv
`default_nettype none

module spi_fram_model
	import fram_cfg_pkg::*;
(
	input  logic fram_cs_n,
	input  logic fram_sclk,
	input  logic fram_mosi,
	output logic fram_miso
);

	// Only the low eleven address bits are decoded
	fram_byte_t  mem [0:2047];
	logic [23:0] cmd_shift;
	int          cmd_bits;
	int          data_bits;
	fram_byte_t  last_opcode;
	fram_addr_t  last_addr;

	////////////////////////////////////////////////////////////////////////////
	// Command and address, sampled on rising SCLK
	////////////////////////////////////////////////////////////////////////////

	always @(posedge fram_sclk or negedge fram_cs_n)
	begin
		if (!fram_sclk)
		begin
			// Chip select just fell, new transaction
			cmd_bits  <= 0;
			data_bits <= 0;
		end
		else if (cmd_bits < 24)
		begin
			cmd_shift <= {cmd_shift[22:0], fram_mosi};
			cmd_bits  <= cmd_bits + 1;
			if (cmd_bits == 23)
			begin
				last_opcode <= cmd_shift[22:15];
				last_addr   <= {cmd_shift[14:0], fram_mosi};
			end
		end
		else
		begin
			// Master has taken one more data bit
			data_bits <= data_bits + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read data, shifted out on falling SCLK
	////////////////////////////////////////////////////////////////////////////

	// MSB first, address auto increments every eight bits
	always @(negedge fram_sclk)
	begin
		if (!fram_cs_n && cmd_bits == 24)
			fram_miso <= mem[11'(last_addr + 16'(data_bits / 8))][3'(7 - data_bits % 8)];
	end

endmodule

`default_nettype wire

// File: verification/tb_fram_cfg.sv
`default_nettype none

module tb_fram_cfg
	import fram_cfg_pkg::*;
();

	localparam int NUM_LOADS    = 4;
	localparam int LOAD_CYCLES  = (int'(CFG_LOAD_LEN) + 3) * 16;
	localparam int WATCHDOG_CYC = NUM_LOADS * (LOAD_CYCLES + int'(CFG_LOAD_LEN) + 100) + 1000;

	logic       sys_clk;
	logic       glbl_rst_n;
	logic       load_start;
	logic       load_done;
	logic       load_error;
	crc_t       load_crc;
	fram_addr_t cfg_rd_addr;
	fram_byte_t cfg_rd_data;
	logic       fram_cs_n;
	logic       fram_sclk;
	logic       fram_mosi;
	logic       fram_miso;

	// Image as stored in the FRAM with its CRC in the last four bytes
	fram_byte_t image [0:CFG_LOAD_LEN-1];

	int failures;
	int cyc;
	int byte_cnt;
	int done_cnt;
	int error_cnt;
	int last_cyc;
	int pulse_cyc;
	int strobe_cyc;
	bit mid_image;

	fram_cfg_top i_dut (
		.sys_clk     (sys_clk),
		.glbl_rst_n  (glbl_rst_n),
		.load_start  (load_start),
		.load_done   (load_done),
		.load_error  (load_error),
		.load_crc    (load_crc),
		.cfg_rd_addr (cfg_rd_addr),
		.cfg_rd_data (cfg_rd_data),
		.fram_cs_n   (fram_cs_n),
		.fram_sclk   (fram_sclk),
		.fram_mosi   (fram_mosi),
		.fram_miso   (fram_miso)
	);

	spi_fram_model i_fram (
		.fram_cs_n (fram_cs_n),
		.fram_sclk (fram_sclk),
		.fram_mosi (fram_mosi),
		.fram_miso (fram_miso)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever
			#50 sys_clk = ~sys_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			failures++;
			$display("error: time %0t signal %s actual %h expected %h",
				$time, name, actual, expected);
			abort_run();
		end
	endtask

	// Bit serial IEEE 802.3 CRC-32 over the first n image bytes
	function automatic crc_t image_crc32(input int n);
		crc_t c;
		c = CRC_INIT;
		for (int i = 0; i < n; i++)
		begin
			c = c ^ {24'd0, image[i]};
			for (int b = 0; b < 8; b++)
			begin
				if (c[0])
					c = (c >> 1) ^ CRC_POLY_REFL;
				else
					c = c >> 1;
			end
		end
		return ~c;
	endfunction

	// Random payload with its CRC appended LSB first and optionally one bit flipped
	task automatic make_image(input bit flip);
		crc_t crc;
		int   pos;
		for (int i = 0; i < CFG_LOAD_LEN - 4; i++)
			image[i] = 8'($urandom);
		crc = image_crc32(CFG_LOAD_LEN - 4);
		for (int i = 0; i < 4; i++)
			image[CFG_LOAD_LEN - 4 + i] = crc[8*i +: 8];
		if (flip)
		begin
			pos = int'($urandom_range(CFG_LOAD_LEN * 8 - 1, 0));
			image[pos / 8] = image[pos / 8] ^ (8'h01 << (pos % 8));
		end
		for (int i = 0; i < CFG_LOAD_LEN; i++)
			i_fram.mem[i] = image[i];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Event monitor sampled mid cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge sys_clk)
	begin
		cyc <= cyc + 1;
		if (i_dut.byte_valid)
		begin
			byte_cnt <= byte_cnt + 1;
			// Eight SCLK bits per byte within one image
			if (mid_image)
				check_value("byte strobe spacing", 32'(cyc - strobe_cyc), 32'd16);
			strobe_cyc <= cyc;
			mid_image  <= !i_dut.byte_last;
		end
		if (i_dut.byte_valid && i_dut.byte_last)
			last_cyc <= cyc;
		if (load_done)
			done_cnt <= done_cnt + 1;
		if (load_error)
			error_cnt <= error_cnt + 1;
		if (load_done || load_error)
			pulse_cyc <= cyc;
	end

	////////////////////////////////////////////////////////////////////////////
	// Load and readback sequences
	////////////////////////////////////////////////////////////////////////////

	task automatic run_load(input bit expect_good, input bit extra_start);
		int   done_base;
		int   error_base;
		int   byte_base;
		crc_t stored;
		done_base  = done_cnt;
		error_base = error_cnt;
		byte_base  = byte_cnt;
		@(posedge sys_clk);
		load_start <= 1'b1;
		@(posedge sys_clk);
		load_start <= 1'b0;
		if (extra_start)
		begin
			repeat ($urandom_range(4000, 200)) @(posedge sys_clk);
			load_start <= 1'b1;
			@(posedge sys_clk);
			load_start <= 1'b0;
		end
		while (done_cnt == done_base && error_cnt == error_base)
			@(negedge sys_clk);
		// Room for a stray second completion
		repeat (64) @(negedge sys_clk);
		check_value("spi opcode", 32'(i_fram.last_opcode), 32'(FRAM_CMD_READ));
		check_value("spi address", 32'(i_fram.last_addr), 32'h0);
		check_value("byte strobes", 32'(byte_cnt - byte_base), 32'(CFG_LOAD_LEN));
		check_value("load_done pulses", 32'(done_cnt - done_base),
			expect_good ? 32'd1 : 32'd0);
		check_value("load_error pulses", 32'(error_cnt - error_base),
			expect_good ? 32'd0 : 32'd1);
		check_value("completion latency", 32'(pulse_cyc - last_cyc), 32'd2);
		stored = {image[CFG_LOAD_LEN - 1], image[CFG_LOAD_LEN - 2],
			image[CFG_LOAD_LEN - 3], image[CFG_LOAD_LEN - 4]};
		check_value("load_crc", load_crc, stored);
		// Part deselected with SCLK parked low
		check_value("fram_cs_n", 32'(fram_cs_n), 32'd1);
		check_value("fram_sclk", 32'(fram_sclk), 32'd0);
	endtask

	// Address issued on one edge and data checked in the following cycle
	task automatic read_back_ram();
		for (int i = 0; i <= CFG_LOAD_LEN; i++)
		begin
			@(posedge sys_clk);
			if (i < CFG_LOAD_LEN)
				cfg_rd_addr <= CFG_BASE_ADDR + 16'(i);
			@(negedge sys_clk);
			if (i > 0)
				check_value($sformatf("cfg_rd_data[%0d]", i - 1), 32'(cfg_rd_data),
					32'(image[i - 1]));
		end
	endtask

	initial
	begin
		glbl_rst_n  = 1'b0;
		load_start  = 1'b0;
		cfg_rd_addr = '0;
		void'($urandom(32'hbb3a));
		repeat (16) @(posedge sys_clk);
		glbl_rst_n <= 1'b1;
		repeat (4) @(posedge sys_clk);

		// Everything quiet out of reset
		@(negedge sys_clk);
		check_value("load_done", 32'(load_done), 32'd0);
		check_value("load_error", 32'(load_error), 32'd0);
		check_value("fram_cs_n", 32'(fram_cs_n), 32'd1);
		check_value("fram_sclk", 32'(fram_sclk), 32'd0);
		check_value("rd_req", 32'(i_dut.rd_req), 32'd0);
		check_value("byte_valid", 32'(i_dut.byte_valid), 32'd0);
		check_value("wr_en", 32'(i_dut.wr_en), 32'd0);

		make_image(1'b0);
		run_load(1'b1, 1'b0);
		read_back_ram();

		// Corrupted image
		make_image(1'b1);
		run_load(1'b0, 1'b0);

		// Second start mid load while new contents replace the old ones
		make_image(1'b0);
		run_load(1'b1, 1'b1);
		read_back_ram();

		make_image(1'b0);
		run_load(1'b1, 1'b0);
		read_back_ram();

		if (failures == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			abort_run();
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge sys_clk);
		$display("Watchdog expired, the loads did not finish within %0d cycles",
			WATCHDOG_CYC);
		abort_run();
	end

endmodule

`default_nettype wire

// File: vlog.f
verilog/fram_cfg_pkg.sv
verilog/crc32_byte_check.sv
verilog/fram_spi_reader.sv
verilog/fram_load_cons.sv
verilog/cons_ram.sv
verilog/fram_cfg_top.sv
verification/spi_fram_model.sv
verification/tb_fram_cfg.sv

// File: run_sim.sh
#!/bin/sh
# Build tb_fram_cfg with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_fram_cfg -f vlog.f \
	&& ./obj_dir/Vtb_fram_cfg > sim.log 2>&1 \
	|| echo "Build or simulation ended with a non zero status"

cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
